// File: include/store_path_macros.svh
`ifndef STORE_PATH_MACROS_SVH
`define STORE_PATH_MACROS_SVH

// bus widths of the store path
`define STORE_ADDR_W 32
`define STORE_DATA_W 32
`define STORE_STRB_W 4

// store buffer entries
`define STORE_FIFO_DEPTH 4

// single write id, every store uses it
`define STORE_AXI_ID_W 4
`define STORE_AXI_ID 1

// fixed kuseg translation when no tlb is present
`define KUSEG_OFFSET 32'h4000_0000

`endif

// File: hdl/mips_addr_pkg.sv
package mips_addr_pkg;

    // segment view of a virtual address
    typedef struct packed {
        logic [2:0]  segment;
        logic [28:0] low;
    } addr_seg_t;

    // byte lane view of the same word
    typedef struct packed {
        logic [29:0] word_idx;
        logic [1:0]  byte_off;
    } addr_lane_t;

    typedef union packed {
        addr_seg_t  seg;
        addr_lane_t lane;
    } addr_word_u;

    // unmapped segments, physical address is the low 29 bits
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    // store size codes from the memory stage
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

endpackage

// File: hdl/axi_wr_pkg.sv
package axi_wr_pkg;

    // awsize, bytes per beat
    localparam logic [2:0] AXI_SIZE_1B = 3'b000;
    localparam logic [2:0] AXI_SIZE_2B = 3'b001;
    localparam logic [2:0] AXI_SIZE_4B = 3'b010;

    // awburst
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    // awlen is beats minus one, axi3 width
    localparam logic [3:0] AXI_LEN_SINGLE = 4'h0;

    // bresp
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// File: hdl/store_align.sv
`timescale 1ns/1ps
`include "store_path_macros.svh"

module store_align (
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       st_valid,
    input  mips_addr_pkg::addr_word_u  st_addr,
    input  logic [1:0]                 st_size,
    input  logic [`STORE_DATA_W-1:0]   st_data,
    input  logic                       st_busy,
    output logic                       push,
    output logic                       st_ex,
    output logic [`STORE_ADDR_W-1:0]   paddr,
    output logic [`STORE_STRB_W-1:0]   strb,
    output logic [`STORE_DATA_W-1:0]   data,
    output logic [1:0]                 size
);

    logic [`STORE_ADDR_W-1:0] map_addr;
    logic [`STORE_STRB_W-1:0] map_strb;
    logic [`STORE_DATA_W-1:0] map_data;
    logic                     misaligned;

    // fixed translation, no tlb
    always_comb begin
        case (st_addr.seg.segment)
            mips_addr_pkg::SEG_KSEG0,
            mips_addr_pkg::SEG_KSEG1: map_addr = {3'b000, st_addr.seg.low};
            default: begin
                // kuseg has the top bit clear, kseg2/kseg3 map one to one
                if (!st_addr.seg.segment[2]) begin
                    map_addr = st_addr + `KUSEG_OFFSET;
                end else begin
                    map_addr = st_addr;
                end
            end
        endcase
    end

    // lane select and data replication
    always_comb begin
        misaligned = 1'b0;
        map_strb   = '0;
        map_data   = st_data;
        case (st_size)
            mips_addr_pkg::SIZE_BYTE: begin
                map_strb = 4'b0001 << st_addr.lane.byte_off;
                map_data = {4{st_data[7:0]}};
            end
            mips_addr_pkg::SIZE_HALF: begin
                misaligned = st_addr.lane.byte_off[0];
                map_strb   = st_addr.lane.byte_off[1] ? 4'b1100 : 4'b0011;
                map_data   = {2{st_data[15:0]}};
            end
            mips_addr_pkg::SIZE_WORD: begin
                misaligned = (st_addr.lane.byte_off != 2'b00);
                map_strb   = 4'b1111;
            end
            // undefined size code is rejected like a misaligned store
            default: misaligned = 1'b1;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            push  <= 1'b0;
            st_ex <= 1'b0;
        end else begin
            push  <= st_valid && !misaligned;
            st_ex <= st_valid && misaligned;
        end
    end

    always_ff @(posedge aclk) begin
        if (st_valid) begin
            paddr <= map_addr;
            strb  <= map_strb;
            data  <= map_data;
            size  <= st_size;
        end
    end

    // caller must hold off while the buffer reports busy
    assert property (@(posedge aclk) disable iff (rst) st_valid |-> !st_busy);

endmodule

// File: hdl/store_fifo.sv
`timescale 1ns/1ps
`include "store_path_macros.svh"

module store_fifo (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      push,
    input  logic [`STORE_ADDR_W-1:0]  paddr,
    input  logic [`STORE_STRB_W-1:0]  strb,
    input  logic [`STORE_DATA_W-1:0]  data,
    input  logic [1:0]                size,
    input  logic                      pop,
    output logic [`STORE_ADDR_W-1:0]  head_addr,
    output logic [`STORE_STRB_W-1:0]  head_strb,
    output logic [`STORE_DATA_W-1:0]  head_data,
    output logic [1:0]                head_size,
    output logic                      not_empty,
    output logic                      full_soon
);

    localparam int DEPTH = `STORE_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [`STORE_ADDR_W-1:0] addr_mem [DEPTH];
    logic [`STORE_STRB_W-1:0] strb_mem [DEPTH];
    logic [`STORE_DATA_W-1:0] data_mem [DEPTH];
    logic [1:0]               size_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            addr_mem[wr_ptr] <= paddr;
            strb_mem[wr_ptr] <= strb;
            data_mem[wr_ptr] <= data;
            size_mem[wr_ptr] <= size;
        end
    end

    assign head_addr = addr_mem[rd_ptr];
    assign head_strb = strb_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_size = size_mem[rd_ptr];
    assign not_empty = (count != '0);
    // one slot left for the store already registered upstream
    assign full_soon = (count >= CNT_W'(DEPTH - 1));

    assert property (@(posedge aclk) disable iff (rst) push |-> count != CNT_W'(DEPTH));
    assert property (@(posedge aclk) disable iff (rst) pop |-> count != '0);

endmodule

// File: hdl/axi_store_writer.sv
`timescale 1ns/1ps
`include "store_path_macros.svh"

module axi_store_writer (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic [`STORE_ADDR_W-1:0]    head_addr,
    input  logic [`STORE_STRB_W-1:0]    head_strb,
    input  logic [`STORE_DATA_W-1:0]    head_data,
    input  logic [1:0]                  head_size,
    input  logic                        not_empty,
    input  logic                        awready,
    input  logic                        wready,
    input  logic [`STORE_AXI_ID_W-1:0]  bid,
    input  logic [1:0]                  bresp,
    input  logic                        bvalid,
    output logic                        pop,
    output logic [`STORE_AXI_ID_W-1:0]  awid,
    output logic [`STORE_ADDR_W-1:0]    awaddr,
    output logic [3:0]                  awlen,
    output logic [2:0]                  awsize,
    output logic [1:0]                  awburst,
    output logic                        awvalid,
    output logic [`STORE_AXI_ID_W-1:0]  wid,
    output logic [`STORE_DATA_W-1:0]    wdata,
    output logic [`STORE_STRB_W-1:0]    wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    output logic                        bready,
    output logic                        bus_err,
    output logic                        busy
);

    localparam logic [`STORE_AXI_ID_W-1:0] WR_ID = `STORE_AXI_ID;

    typedef enum logic [1:0] {IDLE, ADDR_DATA, RESP} state_t;
    state_t state;

    logic aw_done;
    logic w_done;

    // a channel is finished once its valid is gone or is being taken now
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    assign pop = (state == IDLE) && not_empty;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bus_err <= 1'b0;
        end else begin
            bus_err <= 1'b0;
            case (state)
                IDLE: if (pop) begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                    state   <= ADDR_DATA;
                end
                ADDR_DATA: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_done && w_done) state <= RESP;
                end
                default: if (bvalid) begin
                    bus_err <= (bresp != axi_wr_pkg::AXI_RESP_OKAY);
                    state   <= IDLE;
                end
            endcase
        end
    end

    // head entry held for the whole transaction
    always_ff @(posedge aclk) begin
        if (pop) begin
            awaddr <= head_addr;
            wdata  <= head_data;
            wstrb  <= head_strb;
            case (head_size)
                mips_addr_pkg::SIZE_BYTE: awsize <= axi_wr_pkg::AXI_SIZE_1B;
                mips_addr_pkg::SIZE_HALF: awsize <= axi_wr_pkg::AXI_SIZE_2B;
                default: awsize <= axi_wr_pkg::AXI_SIZE_4B;
            endcase
        end
    end

    assign awid    = WR_ID;
    assign wid     = WR_ID;
    assign awlen   = axi_wr_pkg::AXI_LEN_SINGLE;
    assign awburst = axi_wr_pkg::AXI_BURST_INCR;
    assign wlast   = 1'b1;
    assign bready  = (state == RESP);
    assign busy    = pop || (state != IDLE);

    assert property (@(posedge aclk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr));
    // only one write in flight, so the response must carry our id
    assert property (@(posedge aclk) disable iff (rst) bvalid && bready |-> bid == awid);

endmodule

// File: hdl/uncached_store_top.sv
`timescale 1ns/1ps
`include "store_path_macros.svh"

module uncached_store_top (
    input  logic                        aclk,
    input  logic                        rst,
    input  logic                        st_valid,
    input  mips_addr_pkg::addr_word_u   st_addr,
    input  logic [1:0]                  st_size,
    input  logic [`STORE_DATA_W-1:0]    st_data,
    output logic                        st_busy,
    output logic                        st_ex,
    output logic                        store_record,
    output logic                        bus_err,
    output logic [`STORE_AXI_ID_W-1:0]  awid,
    output logic [`STORE_ADDR_W-1:0]    awaddr,
    output logic [3:0]                  awlen,
    output logic [2:0]                  awsize,
    output logic [1:0]                  awburst,
    output logic                        awvalid,
    input  logic                        awready,
    output logic [`STORE_AXI_ID_W-1:0]  wid,
    output logic [`STORE_DATA_W-1:0]    wdata,
    output logic [`STORE_STRB_W-1:0]    wstrb,
    output logic                        wlast,
    output logic                        wvalid,
    input  logic                        wready,
    input  logic [`STORE_AXI_ID_W-1:0]  bid,
    input  logic [1:0]                  bresp,
    input  logic                        bvalid,
    output logic                        bready
);

    logic                     push;
    logic                     pop;
    logic [`STORE_ADDR_W-1:0] paddr;
    logic [`STORE_STRB_W-1:0] strb;
    logic [`STORE_DATA_W-1:0] data;
    logic [1:0]               size;
    logic [`STORE_ADDR_W-1:0] head_addr;
    logic [`STORE_STRB_W-1:0] head_strb;
    logic [`STORE_DATA_W-1:0] head_data;
    logic [1:0]               head_size;
    logic                     not_empty;
    logic                     full_soon;
    logic                     writer_busy;

    assign st_busy = full_soon;

    // stores still owed to memory, in the buffer, on the bus or arriving
    assign store_record = not_empty || writer_busy || push;

    store_align i_store_align (
        .aclk     (aclk),
        .rst      (rst),
        .st_valid (st_valid),
        .st_addr  (st_addr),
        .st_size  (st_size),
        .st_data  (st_data),
        .st_busy  (st_busy),
        .push     (push),
        .st_ex    (st_ex),
        .paddr    (paddr),
        .strb     (strb),
        .data     (data),
        .size     (size)
    );

    store_fifo i_store_fifo (
        .aclk      (aclk),
        .rst       (rst),
        .push      (push),
        .paddr     (paddr),
        .strb      (strb),
        .data      (data),
        .size      (size),
        .pop       (pop),
        .head_addr (head_addr),
        .head_strb (head_strb),
        .head_data (head_data),
        .head_size (head_size),
        .not_empty (not_empty),
        .full_soon (full_soon)
    );

    axi_store_writer i_axi_store_writer (
        .aclk      (aclk),
        .rst       (rst),
        .head_addr (head_addr),
        .head_strb (head_strb),
        .head_data (head_data),
        .head_size (head_size),
        .not_empty (not_empty),
        .awready   (awready),
        .wready    (wready),
        .bid       (bid),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .pop       (pop),
        .awid      (awid),
        .awaddr    (awaddr),
        .awlen     (awlen),
        .awsize    (awsize),
        .awburst   (awburst),
        .awvalid   (awvalid),
        .wid       (wid),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wlast     (wlast),
        .wvalid    (wvalid),
        .bready    (bready),
        .bus_err   (bus_err),
        .busy      (writer_busy)
    );

endmodule

// File: bench/tb_uncached_store.sv
`timescale 1ns/1ps
`include "store_path_macros.svh"

module tb_uncached_store;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int N_TESTS      = 6;
    localparam int TEST_CYCLES  = 120;
    localparam int MARGIN       = 4;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + N_TESTS * TEST_CYCLES) * MARGIN * CLK_PERIOD;
    localparam int DRAIN_LIMIT  = 100;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic                       aclk;
    logic                       rst;
    logic                       st_valid;
    mips_addr_pkg::addr_word_u  st_addr;
    logic [1:0]                 st_size;
    logic [`STORE_DATA_W-1:0]   st_data;
    logic                       st_busy;
    logic                       st_ex;
    logic                       store_record;
    logic                       bus_err;
    logic [`STORE_AXI_ID_W-1:0] awid;
    logic [`STORE_ADDR_W-1:0]   awaddr;
    logic [3:0]                 awlen;
    logic [2:0]                 awsize;
    logic [1:0]                 awburst;
    logic                       awvalid;
    logic                       awready;
    logic [`STORE_AXI_ID_W-1:0] wid;
    logic [`STORE_DATA_W-1:0]   wdata;
    logic [`STORE_STRB_W-1:0]   wstrb;
    logic                       wlast;
    logic                       wvalid;
    logic                       wready;
    logic [`STORE_AXI_ID_W-1:0] bid;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;

    // slave model controls and counters
    logic        aw_stall;
    logic [1:0]  next_resp;
    int          aw_seen = 0;
    int          w_seen = 0;
    int          b_sent = 0;
    int          b_done = 0;
    logic [31:0] cap_addr[$];
    logic [2:0]  cap_size[$];
    logic [3:0]  cap_len[$];
    logic [31:0] cap_data[$];
    logic [3:0]  cap_strb[$];

    // expected writes in issue order
    logic [31:0] exp_addr[$];
    logic [2:0]  exp_size[$];
    logic [31:0] exp_data[$];
    logic [3:0]  exp_strb[$];

    int          errors = 0;
    int          tests_run = 0;
    int          test_base = 0;
    int          b_base = 0;
    int          ex_count = 0;
    int          err_count = 0;
    int          rec_count = 0;
    logic [31:0] lfsr = 32'ha31e74a0;

    uncached_store_top i_uncached_store_top (.*);

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    assign awready = !aw_stall;
    assign wready  = 1'b1;

    // pulse and level counters
    always @(posedge aclk) begin
        if (!rst && st_ex) ex_count++;
        if (!rst && bus_err) err_count++;
        if (!rst && store_record) rec_count++;
    end

    // axi slave model with one response per accepted aw/w pair
    always @(posedge aclk) begin : axi_slave
        logic hs;
        hs = bvalid && bready;
        if (!rst) begin
            if (awvalid && awready) begin
                cap_addr.push_back(awaddr);
                cap_size.push_back(awsize);
                cap_len.push_back(awlen);
                check_val("awburst", awburst, axi_wr_pkg::AXI_BURST_INCR);
                check_val("awid", awid, `STORE_AXI_ID);
                aw_seen++;
            end
            if (wvalid && wready) begin
                cap_data.push_back(wdata);
                cap_strb.push_back(wstrb);
                check_val("wlast", wlast, 1'b1);
                check_val("wid", wid, `STORE_AXI_ID);
                w_seen++;
            end
            if (hs) b_done++;
        end
        #1;
        if (hs || rst) bvalid = 1'b0;
        if (!rst && !bvalid && aw_seen > b_sent && w_seen > b_sent) begin
            bvalid = 1'b1;
            bresp  = next_resp;
            b_sent++;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else begin
            errors++;
            $display("%s", what);
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic void record_expected(input mips_addr_pkg::addr_word_u va,
                                            input logic [1:0] size, input logic [31:0] d);
        logic [31:0] pa;
        logic [3:0]  lanes;
        int          nbytes;
        int          off;
        if (va.seg.segment == mips_addr_pkg::SEG_KSEG0 ||
            va.seg.segment == mips_addr_pkg::SEG_KSEG1) begin
            pa = {3'b000, va.seg.low};
        end else if (va.seg.segment < 3'd4) begin
            pa = 32'(va) + `KUSEG_OFFSET;
        end else begin
            pa = va;
        end
        exp_addr.push_back(pa);
        case (size)
            mips_addr_pkg::SIZE_BYTE: begin
                nbytes = 1;
                exp_data.push_back({4{d[7:0]}});
                exp_size.push_back(3'd0);
            end
            mips_addr_pkg::SIZE_HALF: begin
                nbytes = 2;
                exp_data.push_back({2{d[15:0]}});
                exp_size.push_back(3'd1);
            end
            default: begin
                nbytes = 4;
                exp_data.push_back(d);
                exp_size.push_back(3'd2);
            end
        endcase
        // a lane is written when it lies inside the stored bytes
        off = va.seg.low[1:0];
        for (int i = 0; i < 4; i++) begin
            lanes[i] = (i >= off) && (i < off + nbytes);
        end
        exp_strb.push_back(lanes);
    endfunction

    task automatic send_store(input logic [31:0] va, input logic [1:0] size,
                              input logic [31:0] d, input logic aligned);
        while (st_busy) begin
            @(posedge aclk);
            #1;
        end
        if (aligned) record_expected(va, size, d);
        st_valid = 1'b1;
        st_addr  = va;
        st_size  = size;
        st_data  = d;
        @(posedge aclk);
        #1;
        st_valid = 1'b0;
    endtask

    // store_record must stay up until every response is back
    task automatic wait_drain();
        int n;
        n = 0;
        while (store_record && n < DRAIN_LIMIT) begin
            @(posedge aclk);
            #1;
            n++;
        end
        check_true(!store_record, "store path still busy after the drain limit");
        check_val("bvalid handshakes", b_done - b_base, exp_addr.size());
    endtask

    task automatic compare_writes();
        check_true(cap_addr.size() == exp_addr.size() && cap_data.size() == exp_addr.size(),
                   "number of AXI writes does not match the stores sent");
        while (exp_addr.size() > 0 && cap_addr.size() > 0 && cap_data.size() > 0) begin
            check_val("awaddr", cap_addr.pop_front(), exp_addr.pop_front());
            check_val("awsize", cap_size.pop_front(), exp_size.pop_front());
            check_val("awlen", cap_len.pop_front(), axi_wr_pkg::AXI_LEN_SINGLE);
            check_val("wdata", cap_data.pop_front(), exp_data.pop_front());
            check_val("wstrb", cap_strb.pop_front(), exp_strb.pop_front());
        end
        cap_addr.delete();
        cap_size.delete();
        cap_len.delete();
        cap_data.delete();
        cap_strb.delete();
        exp_addr.delete();
        exp_size.delete();
        exp_data.delete();
        exp_strb.delete();
    endtask

    task automatic begin_test();
        test_base = errors;
        b_base    = b_done;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_base) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failing checks", name, errors - test_base);
        end
    endtask

    task automatic unmapped_word_stores();
        begin_test();
        send_store(32'ha000_1000, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        send_store(32'h8fc0_0004, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        send_store(32'hbfff_fffc, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        wait_drain();
        compare_writes();
        end_test("word stores to kseg0 and kseg1");
    endtask

    task automatic sub_word_stores();
        begin_test();
        for (int off = 0; off < 4; off++) begin
            send_store(32'ha000_2000 + off, mips_addr_pkg::SIZE_BYTE, lfsr_bits(32), 1'b1);
        end
        send_store(32'h8000_2010, mips_addr_pkg::SIZE_HALF, lfsr_bits(32), 1'b1);
        send_store(32'h8000_2012, mips_addr_pkg::SIZE_HALF, lfsr_bits(32), 1'b1);
        wait_drain();
        compare_writes();
        end_test("byte and half stores");
    endtask

    task automatic mapped_segment_stores();
        begin_test();
        send_store(32'h0000_3008, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        send_store(32'h1234_5671, mips_addr_pkg::SIZE_BYTE, lfsr_bits(32), 1'b1);
        send_store(32'hc000_0010, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        send_store(32'he000_0022, mips_addr_pkg::SIZE_HALF, lfsr_bits(32), 1'b1);
        wait_drain();
        compare_writes();
        end_test("kuseg and kseg2/kseg3 stores");
    endtask

    task automatic misaligned_stores();
        int base_ex;
        int base_rec;
        begin_test();
        base_ex  = ex_count;
        base_rec = rec_count;
        send_store(32'ha000_0001, mips_addr_pkg::SIZE_HALF, lfsr_bits(32), 1'b0);
        send_store(32'ha000_0002, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b0);
        send_store(32'h8000_0003, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b0);
        // leave time for any stray write to show up
        repeat (10) @(posedge aclk);
        #1;
        check_true(ex_count - base_ex == 3, "st_ex did not pulse once per misaligned store");
        check_true(cap_addr.size() == 0 && cap_data.size() == 0,
                   "a misaligned store reached the AXI write channels");
        check_true(rec_count == base_rec, "store_record rose for a rejected store");
        compare_writes();
        end_test("misaligned stores");
    endtask

    task automatic stalled_address_channel();
        int sent;
        begin_test();
        sent = 0;
        aw_stall = 1'b1;
        while (!st_busy && sent < 8) begin
            send_store(32'ha000_4000 + sent * 4, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
            sent++;
        end
        check_true(st_busy, "st_busy did not rise while awready was held low");
        check_true(sent >= `STORE_FIFO_DEPTH, "st_busy rose before the store buffer filled");
        repeat (4) @(posedge aclk);
        #1;
        check_true(store_record, "store_record low while stores were held back");
        check_true(awvalid, "awvalid dropped while awready was held low");
        check_true(cap_data.size() == 1, "write data not accepted while the address was stalled");
        aw_stall = 1'b0;
        wait_drain();
        compare_writes();
        end_test("stalled write address channel");
    endtask

    task automatic error_response();
        int base_err;
        begin_test();
        base_err = err_count;
        next_resp = RESP_SLVERR;
        send_store(32'ha000_5000, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        wait_drain();
        next_resp = axi_wr_pkg::AXI_RESP_OKAY;
        send_store(32'ha000_5004, mips_addr_pkg::SIZE_WORD, lfsr_bits(32), 1'b1);
        wait_drain();
        @(posedge aclk);
        #1;
        check_true(err_count - base_err == 1, "bus_err did not pulse exactly once on SLVERR");
        compare_writes();
        end_test("error response");
    endtask

    initial begin
        aclk      = 1'b0;
        rst       = 1'b1;
        st_valid  = 1'b0;
        st_addr   = '0;
        st_size   = '0;
        st_data   = '0;
        aw_stall  = 1'b0;
        next_resp = axi_wr_pkg::AXI_RESP_OKAY;
        bid       = `STORE_AXI_ID;
        bresp     = axi_wr_pkg::AXI_RESP_OKAY;
        bvalid    = 1'b0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst = 1'b0;
        @(posedge aclk);
        #1;
        unmapped_word_stores();
        sub_word_stores();
        mapped_segment_stores();
        misaligned_stores();
        stalled_address_channel();
        error_response();
        $display("%0d tests run, %0d checks failed", tests_run, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
hdl/mips_addr_pkg.sv
hdl/axi_wr_pkg.sv
hdl/store_align.sv
hdl/store_fifo.sv
hdl/axi_store_writer.sv
hdl/uncached_store_top.sv
bench/tb_uncached_store.sv

// File: Bender.yml
package:
  name: uncached_store

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/mips_addr_pkg.sv
      - hdl/axi_wr_pkg.sv
      - hdl/store_align.sv
      - hdl/store_fifo.sv
      - hdl/axi_store_writer.sv
      - hdl/uncached_store_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_uncached_store.sv
